/* bench/tb_bpu_top.sv */
/*
 * Directed testbench for the branch prediction unit
 * Plays fetch, execute and an APB master against a model of the tables
 */

`timescale 1ns/1ps

module tb_bpu_top
  import bpu_pkg::*;
  import bpu_apb_pkg::*;
();

  logic            clk;
  logic            rst_n;
  logic [XLEN-1:0] pc;
  logic            lookup;
  logic            res_valid;
  resolution_t     res;
  apb_req_t        apb_req;
  logic            pred_valid;
  prediction_t     pred;
  apb_rsp_t        apb_rsp;

  // Model of the BTB rows, the BHT counters and the statistics
  logic        m_valid [16];
  logic [25:0] m_tag [16];
  logic [29:0] m_tgt [16];
  logic [1:0]  m_cnt [64];
  bpu_stats_t  m_stats;
  int          errors;
  int          timeouts;
  int          seed;

  tb_clk_gen clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  bpu_top bpu_top_inst (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .pc_i         (pc),
    .lookup_i     (lookup),
    .res_valid_i  (res_valid),
    .res_i        (res),
    .apb_req_i    (apb_req),
    .pred_valid_o (pred_valid),
    .pred_o       (pred),
    .apb_rsp_o    (apb_rsp)
  );

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_pred(input string name, input prediction_t got, input prediction_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t pred_o (%s) got next_pc=%h taken=%b expected next_pc=%h taken=%b",
               $time, name, got.next_pc, got.taken, exp.next_pc, exp.taken);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t prdata (%s) got %h expected %h", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Model and stimulus helpers
  // --------------------------------------------------
  // Empty BTB, weakly not taken counters, zero statistics
  task automatic model_clear();
    for (int i = 0; i < 16; i++) begin
      m_valid[i] = 1'b0;
    end
    for (int i = 0; i < 64; i++) begin
      m_cnt[i] = 2'b01;
    end
    m_stats = '0;
  endtask

  // Word aligned random address
  function automatic logic [31:0] rand_pc();
    return $random(seed) & 32'hffff_fffc;
  endfunction

  // Fetch side: one lookup, then wait for its prediction
  task automatic lookup_check(input logic [31:0] lpc, input string name);
    prediction_t exp;
    logic        hit;
    int          tries;
    // BTB row is pc[5:2] with tag pc[31:6], BHT counter is pc[7:2]
    hit = m_valid[lpc[5:2]] && (m_tag[lpc[5:2]] == lpc[31:6]);
    exp.taken = hit && m_cnt[lpc[7:2]][1];
    exp.next_pc = exp.taken ? {m_tgt[lpc[5:2]], 2'b00} : lpc + 32'd4;
    m_stats.lookups = m_stats.lookups + 32'd1;
    if (hit) begin
      m_stats.hits = m_stats.hits + 32'd1;
    end
    @(negedge clk);
    pc = lpc;
    lookup = 1'b1;
    @(negedge clk);
    lookup = 1'b0;
    tries = 0;
    while (pred_valid !== 1'b1 && tries < 8) begin
      @(negedge clk);
      tries++;
    end
    if (pred_valid !== 1'b1) begin
      timeouts++;
      $display("Timeout: lookup of %h never got a prediction", lpc);
    end else begin
      // Prediction is due one clock edge after the lookup
      if (tries != 0) begin
        errors++;
        $display("Late prediction: lookup of %h answered %0d cycles late", lpc, tries);
      end
      check_pred(name, pred, exp);
      // Valid is a single-cycle pulse per lookup
      @(negedge clk);
      if (pred_valid !== 1'b0) begin
        errors++;
        $display("[FAIL] %0t pred_valid_o (%s) got %b expected 0", $time, name, pred_valid);
      end
    end
  endtask

  // Execute side: one resolution, mirrored into the model
  task automatic resolve(input logic [31:0] rpc, input logic [31:0] tgt,
                         input logic taken, input logic is_branch, input logic misp);
    @(negedge clk);
    res = {rpc, tgt, taken, is_branch, misp};
    res_valid = 1'b1;
    @(negedge clk);
    res_valid = 1'b0;
    if (!is_branch) begin
      m_valid[rpc[5:2]] = 1'b0;
    end else begin
      if (taken) begin
        m_valid[rpc[5:2]] = 1'b1;
        m_tag[rpc[5:2]] = rpc[31:6];
        m_tgt[rpc[5:2]] = tgt[31:2];
      end
      // Saturating step of the direction counter
      if (taken && m_cnt[rpc[7:2]] != 2'b11) begin
        m_cnt[rpc[7:2]] = m_cnt[rpc[7:2]] + 2'd1;
      end else if (!taken && m_cnt[rpc[7:2]] != 2'b00) begin
        m_cnt[rpc[7:2]] = m_cnt[rpc[7:2]] - 2'd1;
      end
    end
    if (misp) begin
      m_stats.mispredicts = m_stats.mispredicts + 32'd1;
    end
  endtask

  // One APB transfer, setup then access phase
  task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int tries;
    @(negedge clk);
    apb_req = {1'b1, 1'b0, write, addr, wdata};
    @(negedge clk);
    apb_req.penable = 1'b1;
    tries = 0;
    @(posedge clk);
    while (!apb_rsp.pready && tries < 8) begin
      @(posedge clk);
      tries++;
    end
    if (!apb_rsp.pready) begin
      timeouts++;
      $display("Timeout: APB access to offset %h never saw pready", addr);
    end else if (tries != 0) begin
      // Slave has no wait states
      errors++;
      $display("Wait state: APB access to offset %h held off for %0d cycles", addr, tries);
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic check_stats(input string when_s);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, REG_LOOKUPS, 32'h0, rdata, err);
    check_word({"REG_LOOKUPS ", when_s}, rdata, m_stats.lookups);
    apb_xfer(1'b0, REG_HITS, 32'h0, rdata, err);
    check_word({"REG_HITS ", when_s}, rdata, m_stats.hits);
    apb_xfer(1'b0, REG_MISP, 32'h0, rdata, err);
    check_word({"REG_MISP ", when_s}, rdata, m_stats.mispredicts);
    check_word({"pslverr on REG_MISP ", when_s}, {31'b0, err}, 32'h0);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_state();
    check_stats("after reset");
    lookup_check(rand_pc(), "cold lookup");
  endtask

  // Two taken resolutions per random branch, many rows touched
  task automatic test_train(output logic [31:0] last_pc);
    logic [31:0] tgt;
    for (int i = 0; i < 12; i++) begin
      last_pc = rand_pc();
      tgt = rand_pc();
      resolve(last_pc, tgt, 1'b1, 1'b1, 1'b1);
      lookup_check(last_pc, "after one taken");
      resolve(last_pc, tgt, 1'b1, 1'b1, 1'b0);
      lookup_check(last_pc, "after two taken");
    end
  endtask

  // Same row with another tag, then a non-branch deletes the row
  task automatic test_alias(input logic [31:0] pc0);
    lookup_check(pc0 ^ 32'h40, "other tag in same row");
    resolve(pc0, 32'h0, 1'b0, 1'b0, 1'b1);
    lookup_check(pc0, "after delete");
  endtask

  task automatic test_hysteresis(output logic [31:0] hpc);
    logic [31:0] tgt;
    hpc = rand_pc();
    tgt = rand_pc();
    repeat (3) begin
      resolve(hpc, tgt, 1'b1, 1'b1, 1'b0);
    end
    lookup_check(hpc, "counter at 11");
    resolve(hpc, tgt, 1'b0, 1'b1, 1'b1);
    lookup_check(hpc, "one not taken from 11");
    resolve(hpc, tgt, 1'b0, 1'b1, 1'b1);
    lookup_check(hpc, "two not taken from 11");
    repeat (3) begin
      resolve(hpc, tgt, 1'b0, 1'b1, 1'b0);
    end
    lookup_check(hpc, "saturated at 00");
    resolve(hpc, tgt, 1'b1, 1'b1, 1'b1);
    lookup_check(hpc, "one taken from 00");
    repeat (4) begin
      resolve(hpc, tgt, 1'b1, 1'b1, 1'b0);
    end
    lookup_check(hpc, "saturated at 11");
  endtask

  // Clear through REG_CTRL, then an unmapped offset
  task automatic test_clear(input logic [31:0] hpc);
    logic [31:0] rdata;
    logic        err;
    lookup_check(hpc, "before clear");
    apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, err);
    check_word("pslverr on REG_CTRL write", {31'b0, err}, 32'h0);
    model_clear();
    check_stats("after clear");
    lookup_check(hpc, "after clear");
    apb_xfer(1'b0, 8'h10, 32'h0, rdata, err);
    check_word("pslverr at offset 0x10", {31'b0, err}, 32'h1);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int          tries;
    logic [31:0] pc_a;
    logic [31:0] pc_b;
    errors = 0;
    timeouts = 0;
    seed = 32'h72aa040d;
    pc = '0;
    lookup = 1'b0;
    res_valid = 1'b0;
    res = '0;
    apb_req = '0;
    model_clear();
    tries = 0;
    while (rst_n !== 1'b1 && tries < 32) begin
      @(negedge clk);
      tries++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    test_reset_state();
    test_train(pc_a);
    test_alias(pc_a);
    test_hysteresis(pc_b);
    check_stats("after training");
    test_clear(pc_b);
    $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* bench/tb_clk_gen.sv */
/*
 * Testbench clock and reset generator
 * 100 ns clock, reset held low for the first 8 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* design/bht.sv */
/*
 * Branch history table
 * 64 two-bit saturating counters, read by the lookup PC,
 * trained by resolved branches
 */

`timescale 1ns/1ps

module bht
  import bpu_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            clear_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            we_i,
  input  resolution_t     res_i,
  output logic            taken_o
);

  // Weakly not taken is the starting point for every counter
  localparam logic [1:0] CNT_INIT = 2'b01;

  logic [1:0]          cnt_q [BHT_ROWS];
  logic [BHT_BITS-1:0] rd_idx;
  logic [BHT_BITS-1:0] wr_idx;
  logic [1:0]          cnt_cur;
  logic [1:0]          cnt_nxt;

  // Index is pc[7:2] on both ports
  assign rd_idx = pc_i[BHT_BITS+OFFSET-1:OFFSET];
  assign wr_idx = res_i.pc[BHT_BITS+OFFSET-1:OFFSET];

  // --------------------------------------------------
  // Saturating step
  // --------------------------------------------------
  assign cnt_cur = cnt_q[wr_idx];

  always_comb begin
    cnt_nxt = cnt_cur;
    if (res_i.taken) begin
      // Count up, stick at 11
      if (cnt_cur != 2'b11) begin
        cnt_nxt = cnt_cur + 2'd1;
      end
    end else begin
      // Count down, stick at 00
      if (cnt_cur != 2'b00) begin
        cnt_nxt = cnt_cur - 2'd1;
      end
    end
  end

  // Clear beats training
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ROWS; i++) begin
        cnt_q[i] <= CNT_INIT;
      end
    end else if (clear_i) begin
      for (int i = 0; i < BHT_ROWS; i++) begin
        cnt_q[i] <= CNT_INIT;
      end
    end else if (we_i) begin
      cnt_q[wr_idx] <= cnt_nxt;
    end
  end

  // Upper bit decides the direction
  assign taken_o = cnt_q[rd_idx][1];

  // A counter sitting at a limit and pushed further must stay put
  a_saturate: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (we_i && !clear_i &&
     ((res_i.taken && cnt_cur == 2'b11) || (!res_i.taken && cnt_cur == 2'b00)))
    |=> (cnt_q[$past(wr_idx)] == $past(cnt_cur))
  );

endmodule

/* design/bpu_apb_pkg.sv */
/*
 * APB definitions for the branch prediction unit
 * Request and response bundles and the register map
 */

package bpu_apb_pkg;

  // Master to slave
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // --------------------------------------------------
  // Register offsets, one 32-bit word each
  // --------------------------------------------------
  // Bit 0 written as 1 clears both tables and the statistics
  localparam logic [7:0] REG_CTRL    = 8'h00;
  localparam logic [7:0] REG_LOOKUPS = 8'h04;
  localparam logic [7:0] REG_HITS    = 8'h08;
  localparam logic [7:0] REG_MISP    = 8'h0C;

endpackage

/* design/bpu_apb_regs.sv */
/*
 * APB register block for the branch prediction unit
 * Zero wait states. Issues the table clear pulse and
 * returns the statistics counters
 */

`timescale 1ns/1ps

module bpu_apb_regs
  import bpu_pkg::*;
  import bpu_apb_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  apb_req_t   apb_req_i,
  input  bpu_stats_t stats_i,
  output apb_rsp_t   apb_rsp_o,
  output logic       clear_o
);

  logic access;
  logic mapped;
  logic clear_q;

  // Access phase of a transfer
  assign access = apb_req_i.psel && apb_req_i.penable;

  // --------------------------------------------------
  // Address decode and read mux
  // --------------------------------------------------
  always_comb begin
    mapped = 1'b1;
    apb_rsp_o.prdata = '0;
    unique case (apb_req_i.paddr)
      // Clear bit is self-clearing, reads back as zero
      REG_CTRL:    apb_rsp_o.prdata = '0;
      REG_LOOKUPS: apb_rsp_o.prdata = stats_i.lookups;
      REG_HITS:    apb_rsp_o.prdata = stats_i.hits;
      REG_MISP:    apb_rsp_o.prdata = stats_i.mispredicts;
      default:     mapped = 1'b0;
    endcase
    // Keep the bus quiet outside read access phases
    if (!access || apb_req_i.pwrite) begin
      apb_rsp_o.prdata = '0;
    end
  end

  // No wait states
  assign apb_rsp_o.pready  = access;
  assign apb_rsp_o.pslverr = access && !mapped;

  // --------------------------------------------------
  // Clear pulse
  // --------------------------------------------------
  // Fires for one cycle right after the write's access phase
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= access && apb_req_i.pwrite &&
                 (apb_req_i.paddr == REG_CTRL) && apb_req_i.pwdata[0];
    end
  end

  assign clear_o = clear_q;

  // Master protocol: enable only inside a selected transfer
  a_penable_psel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    apb_req_i.penable |-> apb_req_i.psel
  );

endmodule

/* design/bpu_ctrl.sv */
/*
 * Branch prediction controller
 * Registers the prediction from the table outputs, turns resolutions
 * into table writes and keeps the lookup, hit and mispredict counts
 */

`timescale 1ns/1ps

module bpu_ctrl
  import bpu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  logic [XLEN-1:0]        pc_i,
  input  logic                   lookup_i,
  input  logic                   res_valid_i,
  input  resolution_t            res_i,
  input  logic                   btb_hit_i,
  input  logic [XLEN-OFFSET-1:0] btb_target_i,
  input  logic                   bht_taken_i,
  output logic                   btb_we_o,
  output logic                   btb_del_o,
  output logic                   bht_we_o,
  output logic                   pred_valid_o,
  output prediction_t            pred_o,
  output bpu_stats_t             stats_o
);

  logic        pred_valid_q;
  prediction_t pred_q;
  prediction_t pred_d;
  bpu_stats_t  stats_q;

  // --------------------------------------------------
  // Prediction
  // --------------------------------------------------
  // Taken only when the target is known and the counter agrees
  always_comb begin
    pred_d.taken = btb_hit_i && bht_taken_i;
    if (pred_d.taken) begin
      pred_d.next_pc = {btb_target_i, {OFFSET{1'b0}}};
    end else begin
      pred_d.next_pc = pc_i + XLEN'(4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pred_valid_q <= 1'b0;
    end else begin
      pred_valid_q <= lookup_i;
    end
  end

  // Payload only moves on a lookup
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      pred_q <= pred_d;
    end
  end

  assign pred_valid_o = pred_valid_q;
  assign pred_o       = pred_q;

  // --------------------------------------------------
  // Training decode
  // --------------------------------------------------
  // Not a branch: drop its BTB row; taken: record the target
  assign btb_we_o  = res_valid_i && (!res_i.is_branch || res_i.taken);
  assign btb_del_o = !res_i.is_branch;
  // Direction counters only learn from real branches
  assign bht_we_o  = res_valid_i && res_i.is_branch;

  // --------------------------------------------------
  // Statistics
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stats_q <= '0;
    end else if (clear_i) begin
      stats_q <= '0;
    end else begin
      if (lookup_i) begin
        stats_q.lookups <= stats_q.lookups + 32'd1;
      end
      // Hit means a BTB tag match, whatever the direction
      if (lookup_i && btb_hit_i) begin
        stats_q.hits <= stats_q.hits + 32'd1;
      end
      if (res_valid_i && res_i.mispredict) begin
        stats_q.mispredicts <= stats_q.mispredicts + 32'd1;
      end
    end
  end

  assign stats_o = stats_q;

  // Every prediction handed to fetch carries a fully known payload
  a_pred_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pred_valid_o |-> !$isunknown(pred_o)
  );

endmodule

/* design/bpu_pkg.sv */
/*
 * Branch prediction unit core definitions
 * Address and table sizes, execute-stage resolution, fetch-side prediction
 * and the statistics bundle shared between the controller and the APB block
 */

package bpu_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  // Address width
  localparam int unsigned XLEN = 32;
  // Byte offset bits, fixed since compressed instructions are not supported
  localparam int unsigned OFFSET = 2;
  // BTB index bits, 16 rows
  localparam int unsigned BTB_BITS = 4;
  localparam int unsigned BTB_ROWS = 1 << BTB_BITS;
  // Tag is whatever is left above the index
  localparam int unsigned BTB_TAG_BITS = XLEN - BTB_BITS - OFFSET;
  // BHT index bits, 64 counters
  localparam int unsigned BHT_BITS = 6;
  localparam int unsigned BHT_ROWS = 1 << BHT_BITS;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  // One outcome from the execute stage
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] target;
    logic            taken;
    // Low when the instruction was not a control transfer after all
    logic            is_branch;
    logic            mispredict;
  } resolution_t;

  // Answer handed back to fetch
  typedef struct packed {
    logic [XLEN-1:0] next_pc;
    logic            taken;
  } prediction_t;

  // Free-running statistics, wrap at 2^32
  typedef struct packed {
    logic [31:0] lookups;
    logic [31:0] hits;
    logic [31:0] mispredicts;
  } bpu_stats_t;

endpackage

/* design/bpu_top.sv */
/*
 * Branch prediction unit top level
 * BTB and BHT around the prediction controller, with the APB
 * register block for clearing and statistics
 */

`timescale 1ns/1ps

module bpu_top
  import bpu_pkg::*;
  import bpu_apb_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            lookup_i,
  input  logic            res_valid_i,
  input  resolution_t     res_i,
  input  apb_req_t        apb_req_i,
  output logic            pred_valid_o,
  output prediction_t     pred_o,
  output apb_rsp_t        apb_rsp_o
);

  // Table controls and readback
  logic                   clear;
  logic                   btb_we;
  logic                   btb_del;
  logic                   btb_hit;
  logic [XLEN-OFFSET-1:0] btb_target;
  logic                   bht_we;
  logic                   bht_taken;
  bpu_stats_t             stats;

  btb btb_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (clear),
    .pc_i     (pc_i),
    .we_i     (btb_we),
    .del_i    (btb_del),
    .res_i    (res_i),
    .hit_o    (btb_hit),
    .target_o (btb_target)
  );

  bht bht_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (clear),
    .pc_i    (pc_i),
    .we_i    (bht_we),
    .res_i   (res_i),
    .taken_o (bht_taken)
  );

  bpu_ctrl bpu_ctrl_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear),
    .pc_i         (pc_i),
    .lookup_i     (lookup_i),
    .res_valid_i  (res_valid_i),
    .res_i        (res_i),
    .btb_hit_i    (btb_hit),
    .btb_target_i (btb_target),
    .bht_taken_i  (bht_taken),
    .btb_we_o     (btb_we),
    .btb_del_o    (btb_del),
    .bht_we_o     (bht_we),
    .pred_valid_o (pred_valid_o),
    .pred_o       (pred_o),
    .stats_o      (stats)
  );

  bpu_apb_regs bpu_apb_regs_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req_i),
    .stats_i   (stats),
    .apb_rsp_o (apb_rsp_o),
    .clear_o   (clear)
  );

endmodule

/* design/btb.sv */
/*
 * Branch target buffer
 * Direct mapped and tagged, targets stored without the byte offset.
 * Combinational read, write or delete from a resolution, bulk clear
 */

`timescale 1ns/1ps

module btb
  import bpu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   clear_i,
  input  logic [XLEN-1:0]        pc_i,
  input  logic                   we_i,
  input  logic                   del_i,
  input  resolution_t            res_i,
  output logic                   hit_o,
  output logic [XLEN-OFFSET-1:0] target_o
);

  // Valid bits are control state, tag and target are plain storage
  logic [BTB_ROWS-1:0]     valid_q;
  logic [BTB_TAG_BITS-1:0] tag_q [BTB_ROWS];
  logic [XLEN-OFFSET-1:0]  tgt_q [BTB_ROWS];

  logic [BTB_BITS-1:0]     rd_idx;
  logic [BTB_TAG_BITS-1:0] rd_tag;
  logic [BTB_BITS-1:0]     wr_idx;
  logic [BTB_TAG_BITS-1:0] wr_tag;

  // --------------------------------------------------
  // Index and tag split
  // --------------------------------------------------
  // Index is pc[5:2], tag is pc[31:6]
  assign rd_idx = pc_i[BTB_BITS+OFFSET-1:OFFSET];
  assign rd_tag = pc_i[XLEN-1:BTB_BITS+OFFSET];
  assign wr_idx = res_i.pc[BTB_BITS+OFFSET-1:OFFSET];
  assign wr_tag = res_i.pc[XLEN-1:BTB_BITS+OFFSET];

  // --------------------------------------------------
  // Row update
  // --------------------------------------------------
  // Clear beats any training in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (clear_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      // Delete drops the row, a write claims it
      valid_q[wr_idx] <= ~del_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!clear_i && we_i) begin
      if (del_i) begin
        tag_q[wr_idx] <= '0;
        tgt_q[wr_idx] <= '0;
      end else begin
        tag_q[wr_idx] <= wr_tag;
        // Low offset bits are always zero, so drop them
        tgt_q[wr_idx] <= res_i.target[XLEN-1:OFFSET];
      end
    end
  end

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = tgt_q[rd_idx];

  // Controller must settle write-vs-delete before a write races a clear
  a_del_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (we_i && clear_i) |-> !$isunknown(del_i)
  );

endmodule

/* tb.f */
design/bpu_pkg.sv
design/bpu_apb_pkg.sv
design/btb.sv
design/bht.sv
design/bpu_ctrl.sv
design/bpu_apb_regs.sv
design/bpu_top.sv
bench/tb_clk_gen.sv
bench/tb_bpu_top.sv
